// File: verilog.f
+incdir+bench
source/core_pkg.sv
source/data_mem.sv
source/operand_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/backend_top.sv
bench/backend_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= backend_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/backend_model.svh
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

// ========================================
// Sequential reference of the back end
// ========================================
logic [core_pkg::XLEN-1:0] ref_regs [32];
logic [core_pkg::XLEN-1:0] ref_mem [64];
logic [core_pkg::XLEN-1:0] ref_retired;

task automatic reset_reference();
    for (int i = 0; i < 32; i++) begin
        ref_regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        ref_mem[i] = '0;
    end
    ref_retired = '0;
endtask

// Applies one operation in program order and returns what it should retire with
function automatic core_pkg::retire_t run_reference(input core_pkg::issue_op_t op);
    core_pkg::retire_t         rec;
    logic [core_pkg::XLEN-1:0] a;
    logic [core_pkg::XLEN-1:0] b;
    logic [core_pkg::XLEN-1:0] addr;
    logic [core_pkg::XLEN-1:0] res;
    a    = ref_regs[op.rs1];
    b    = ref_regs[op.rs2];
    addr = a + op.imm;
    res  = '0;
    case (op.opcode)
        core_pkg::OP_ADD:   res = a + b;
        core_pkg::OP_SUB:   res = a - b;
        core_pkg::OP_AND:   res = a & b;
        core_pkg::OP_OR:    res = a | b;
        core_pkg::OP_XOR:   res = a ^ b;
        core_pkg::OP_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        core_pkg::OP_SLL:   res = a << b[4:0];
        core_pkg::OP_SRL:   res = a >> b[4:0];
        core_pkg::OP_ADDI:  res = addr;
        core_pkg::OP_LUI:   res = op.imm;
        core_pkg::OP_LOAD:  res = ref_mem[addr[7:2]];
        core_pkg::OP_STORE: ref_mem[addr[7:2]] = b;
        core_pkg::OP_LINK:  res = op.pc + 32'd4;
        core_pkg::OP_CSR:   res = ref_retired;
        default:            res = '0;
    endcase
    rec.pc    = op.pc;
    rec.rd    = op.rd;
    rec.we    = op.opcode != core_pkg::OP_STORE;
    rec.wdata = res;
    if (rec.we && op.rd != '0) begin
        ref_regs[op.rd] = res;
    end
    ref_retired = ref_retired + 32'd1;
    return rec;
endfunction

`endif

// File: bench/backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module backend_tb;

    typedef struct packed {
        logic [31:0]       cycle;
        core_pkg::retire_t rec;
    } expect_t;

    logic                        clk;
    logic                        arst_n_i;
    logic                        issue_valid_i;
    core_pkg::issue_op_t         issue_op_i;
    logic                        retire_valid_o;
    core_pkg::retire_t           retire_o;

    expect_t                     expected_q[$];
    logic [31:0]                 cycle;
    logic [core_pkg::XLEN-1:0]   next_pc;
    logic [core_pkg::REG_AW-1:0] csr_rd_prev;
    int unsigned                 errors;
    int unsigned                 checked;

    `include "backend_model.svh"

    backend_top dut (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_op_i     (issue_op_i),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    always #5 clk = ~clk;

    // Step to the falling edge and compare whatever retires in this cycle
    task automatic next_cycle();
        expect_t exp;
        @(negedge clk);
        cycle = cycle + 32'd1;
        if (expected_q.size() != 0 && expected_q[0].cycle == cycle) begin
            exp = expected_q.pop_front();
            checked++;
            assert (retire_valid_o) else begin
                errors++;
                $display("CHECK FAILED at %0t: pc %08h did not retire", $time, exp.rec.pc);
            end
            assert (retire_o.pc == exp.rec.pc && retire_o.rd == exp.rec.rd
                    && retire_o.we == exp.rec.we
                    && (!exp.rec.we || retire_o.wdata == exp.rec.wdata)) else begin
                errors++;
                $display("CHECK FAILED at %0t: got pc %08h rd %0d we %0b data %08h",
                         $time, retire_o.pc, retire_o.rd, retire_o.we, retire_o.wdata);
                $display("    expected pc %08h rd %0d we %0b data %08h",
                         exp.rec.pc, exp.rec.rd, exp.rec.we, exp.rec.wdata);
            end
        end else begin
            assert (!retire_valid_o) else begin
                errors++;
                $display("CHECK FAILED at %0t: unexpected retire of pc %08h", $time, retire_o.pc);
            end
        end
    endtask

    task automatic send_op(input core_pkg::issue_op_t op);
        expect_t exp;
        op.pc     = next_pc;
        next_pc   = next_pc + 32'd4;
        exp.cycle = cycle + 32'd2;
        exp.rec   = run_reference(op);
        expected_q.push_back(exp);
        issue_valid_i = 1'b1;
        issue_op_i    = op;
        csr_rd_prev   = (op.opcode == core_pkg::OP_CSR) ? op.rd : '0;
    endtask

    task automatic send_idle();
        issue_valid_i = 1'b0;
        issue_op_i    = '0;
        csr_rd_prev   = '0;
    endtask

    // Few registers so that dependent ops come often
    function automatic core_pkg::issue_op_t random_op();
        core_pkg::issue_op_t op;
        op.pc     = '0;
        op.opcode = core_pkg::opcode_e'(4'($urandom_range(13, 0)));
        op.rs1    = 5'($urandom_range(7, 0));
        op.rs2    = 5'($urandom_range(7, 0));
        op.rd     = 5'($urandom_range(7, 0));
        op.imm    = $urandom();
        // A CSR result is not bypassed from execute
        if (csr_rd_prev != '0 && op.rs1 == csr_rd_prev) begin
            op.rs1 = '0;
        end
        if (csr_rd_prev != '0 && op.rs2 == csr_rd_prev) begin
            op.rs2 = '0;
        end
        return op;
    endfunction

    initial begin
        core_pkg::issue_op_t op;
        int unsigned         wait_cycles;
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        issue_valid_i = 1'b0;
        issue_op_i    = '0;
        cycle         = '0;
        next_pc       = 32'h0000_1000;
        csr_rd_prev   = '0;
        errors        = 0;
        checked       = 0;
        void'($urandom(32'h9763));
        reset_reference();
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        // Nothing may retire before the first issue
        repeat (3) next_cycle();

        // ========================================
        // Fill every memory word
        // ========================================
        for (int i = 0; i < 64; i++) begin
            next_cycle();
            op        = '0;
            op.opcode = core_pkg::OP_LUI;
            op.rd     = 5'd1;
            op.imm    = $urandom();
            send_op(op);
            next_cycle();
            op        = '0;
            op.opcode = core_pkg::OP_STORE;
            op.rs2    = 5'd1;
            op.imm    = 32'(i * 4);
            send_op(op);
            // Read the word back right behind its store
            next_cycle();
            op        = '0;
            op.opcode = core_pkg::OP_LOAD;
            op.rd     = 5'd2;
            op.imm    = 32'(i * 4);
            send_op(op);
        end

        // ========================================
        // Random traffic
        // ========================================
        for (int n = 0; n < 2000; n++) begin
            next_cycle();
            if ($urandom_range(3, 0) != 0) begin
                send_op(random_op());
            end else begin
                send_idle();
            end
        end
        next_cycle();
        send_idle();

        wait_cycles = 0;
        while (expected_q.size() != 0 && wait_cycles < 20) begin
            next_cycle();
            wait_cycles++;
        end
        if (expected_q.size() != 0) begin
            errors++;
            $display("Timeout: %0d operations never retired", expected_q.size());
        end

        $display("Retires checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module backend_top (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 issue_valid_i,
    input  core_pkg::issue_op_t  issue_op_i,
    output logic                 retire_valid_o,
    output core_pkg::retire_t    retire_o
);

    logic [core_pkg::REG_AW-1:0] rs1_addr;
    logic [core_pkg::REG_AW-1:0] rs2_addr;
    logic [core_pkg::XLEN-1:0]   rs1_data;
    logic [core_pkg::XLEN-1:0]   rs2_data;

    logic                        ex_fwd_valid;
    logic [core_pkg::REG_AW-1:0] ex_fwd_rd;
    logic [core_pkg::XLEN-1:0]   ex_fwd_data;
    logic                        wb_fwd_valid;
    logic [core_pkg::REG_AW-1:0] wb_fwd_rd;
    logic [core_pkg::XLEN-1:0]   wb_fwd_data;

    logic                        ex_valid;
    core_pkg::ex_op_t            ex_op;
    logic                        wb_valid;
    core_pkg::wb_op_t            wb_op;

    operand_stage u_operand_stage (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_op_i     (issue_op_i),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .ex_fwd_valid_i (ex_fwd_valid),
        .ex_fwd_rd_i    (ex_fwd_rd),
        .ex_fwd_data_i  (ex_fwd_data),
        .wb_fwd_valid_i (wb_fwd_valid),
        .wb_fwd_rd_i    (wb_fwd_rd),
        .wb_fwd_data_i  (wb_fwd_data),
        .ex_valid_o     (ex_valid),
        .ex_op_o        (ex_op)
    );

    execute_stage u_execute_stage (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .ex_valid_i  (ex_valid),
        .ex_op_i     (ex_op),
        .fwd_valid_o (ex_fwd_valid),
        .fwd_rd_o    (ex_fwd_rd),
        .fwd_data_o  (ex_fwd_data),
        .wb_valid_o  (wb_valid),
        .wb_op_o     (wb_op)
    );

    writeback_stage u_writeback_stage (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .wb_valid_i     (wb_valid),
        .wb_op_i        (wb_op),
        .rs1_addr_i     (rs1_addr),
        .rs2_addr_i     (rs2_addr),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data),
        .fwd_valid_o    (wb_fwd_valid),
        .fwd_rd_o       (wb_fwd_rd),
        .fwd_data_o     (wb_fwd_data),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

`default_nettype wire

// File: source/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                         clk,
    input  logic                         arst_n_i,

    input  logic                         wb_valid_i,
    input  core_pkg::wb_op_t             wb_op_i,

    input  logic [core_pkg::REG_AW-1:0]  rs1_addr_i,
    input  logic [core_pkg::REG_AW-1:0]  rs2_addr_i,
    output logic [core_pkg::XLEN-1:0]    rs1_data_o,
    output logic [core_pkg::XLEN-1:0]    rs2_data_o,

    output logic                         fwd_valid_o,
    output logic [core_pkg::REG_AW-1:0]  fwd_rd_o,
    output logic [core_pkg::XLEN-1:0]    fwd_data_o,

    output logic                         retire_valid_o,
    output core_pkg::retire_t            retire_o
);

    logic [core_pkg::XLEN-1:0] regs [2**core_pkg::REG_AW];
    logic [core_pkg::XLEN-1:0] retired_cnt;
    logic [core_pkg::XLEN-1:0] wdata;
    logic                      we;
    core_pkg::wb_sel_e         wb_sel;

    always_comb begin
        case (wb_op_i.opcode)
            core_pkg::OP_LOAD: wb_sel = core_pkg::WB_MEM;
            core_pkg::OP_LINK: wb_sel = core_pkg::WB_PC;
            core_pkg::OP_CSR:  wb_sel = core_pkg::WB_CSR;
            default:           wb_sel = core_pkg::WB_ALU;
        endcase
    end

    // CSR read returns the count before this op retires
    always_comb begin
        case (wb_sel)
            core_pkg::WB_MEM: wdata = wb_op_i.mem_rdata;
            core_pkg::WB_PC:  wdata = wb_op_i.pc + 32'd4;
            core_pkg::WB_CSR: wdata = retired_cnt;
            default:          wdata = wb_op_i.alu_out;
        endcase
    end

    assign we = wb_op_i.opcode != core_pkg::OP_STORE;

    // ========================================
    // Register file and retired counter
    // ========================================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**core_pkg::REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid_i && we && wb_op_i.rd != '0) begin
            regs[wb_op_i.rd] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retired_cnt <= '0;
        end else if (wb_valid_i) begin
            retired_cnt <= retired_cnt + 1'b1;
        end
    end

    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    assign fwd_valid_o = wb_valid_i && we && wb_op_i.rd != '0;
    assign fwd_rd_o    = wb_op_i.rd;
    assign fwd_data_o  = wdata;

    assign retire_valid_o = wb_valid_i;
    assign retire_o.pc    = wb_op_i.pc;
    assign retire_o.rd    = wb_op_i.rd;
    assign retire_o.we    = we;
    assign retire_o.wdata = wdata;

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                         clk,
    input  logic                         arst_n_i,

    input  logic                         ex_valid_i,
    input  core_pkg::ex_op_t             ex_op_i,

    output logic                         fwd_valid_o,
    output logic [core_pkg::REG_AW-1:0]  fwd_rd_o,
    output logic [core_pkg::XLEN-1:0]    fwd_data_o,

    output logic                         wb_valid_o,
    output core_pkg::wb_op_t             wb_op_o
);

    logic [core_pkg::XLEN-1:0] op_a;
    logic [core_pkg::XLEN-1:0] op_b;
    logic [core_pkg::XLEN-1:0] alu_out;
    logic [core_pkg::XLEN-1:0] mem_rdata;
    logic                      mem_we;

    assign op_a = ex_op_i.rs1_val;
    assign op_b = ex_op_i.rs2_val;

    // ========================================
    // ALU
    // ========================================
    always_comb begin
        alu_out = '0;
        case (ex_op_i.opcode)
            core_pkg::OP_ADD: alu_out = op_a + op_b;
            core_pkg::OP_SUB: alu_out = op_a - op_b;
            core_pkg::OP_AND: alu_out = op_a & op_b;
            core_pkg::OP_OR:  alu_out = op_a | op_b;
            core_pkg::OP_XOR: alu_out = op_a ^ op_b;
            core_pkg::OP_SLT: alu_out[0] = $signed(op_a) < $signed(op_b);
            core_pkg::OP_SLL: alu_out = op_a << op_b[4:0];
            core_pkg::OP_SRL: alu_out = op_a >> op_b[4:0];
            // Also the memory address for loads and stores
            core_pkg::OP_ADDI, core_pkg::OP_LOAD, core_pkg::OP_STORE:
                alu_out = op_a + ex_op_i.imm;
            core_pkg::OP_LUI: alu_out = ex_op_i.imm;
            default:          alu_out = '0;
        endcase
    end

    assign mem_we = ex_valid_i && ex_op_i.opcode == core_pkg::OP_STORE;

    data_mem u_data_mem (
        .clk     (clk),
        .we_i    (mem_we),
        .addr_i  (alu_out[core_pkg::DMEM_AW+1:2]),
        .wdata_i (op_b),
        .rdata_o (mem_rdata)
    );

    // CSR value only exists in write-back, so it never forwards from here
    assign fwd_valid_o = ex_valid_i && ex_op_i.rd != '0
                         && ex_op_i.opcode != core_pkg::OP_STORE
                         && ex_op_i.opcode != core_pkg::OP_CSR;
    assign fwd_rd_o    = ex_op_i.rd;

    always_comb begin
        case (ex_op_i.opcode)
            core_pkg::OP_LOAD: fwd_data_o = mem_rdata;
            core_pkg::OP_LINK: fwd_data_o = ex_op_i.pc + 32'd4;
            default:           fwd_data_o = alu_out;
        endcase
    end

    // Write-back pipeline register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_op_o.pc        <= ex_op_i.pc;
        wb_op_o.opcode    <= ex_op_i.opcode;
        wb_op_o.rd        <= ex_op_i.rd;
        wb_op_o.alu_out   <= alu_out;
        wb_op_o.mem_rdata <= mem_rdata;
    end

endmodule

`default_nettype wire

// File: source/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
    input  logic                         clk,
    input  logic                         arst_n_i,

    input  logic                         issue_valid_i,
    input  core_pkg::issue_op_t          issue_op_i,

    output logic [core_pkg::REG_AW-1:0]  rs1_addr_o,
    output logic [core_pkg::REG_AW-1:0]  rs2_addr_o,
    input  logic [core_pkg::XLEN-1:0]    rs1_data_i,
    input  logic [core_pkg::XLEN-1:0]    rs2_data_i,

    input  logic                         ex_fwd_valid_i,
    input  logic [core_pkg::REG_AW-1:0]  ex_fwd_rd_i,
    input  logic [core_pkg::XLEN-1:0]    ex_fwd_data_i,
    input  logic                         wb_fwd_valid_i,
    input  logic [core_pkg::REG_AW-1:0]  wb_fwd_rd_i,
    input  logic [core_pkg::XLEN-1:0]    wb_fwd_data_i,

    output logic                         ex_valid_o,
    output core_pkg::ex_op_t             ex_op_o
);

    core_pkg::ex_op_t ex_next;

    // Younger op in execute wins over the one being written back
    function automatic logic [core_pkg::XLEN-1:0] bypass(
        input logic [core_pkg::REG_AW-1:0] addr,
        input logic [core_pkg::XLEN-1:0]   rf_data,
        input logic                        ex_valid,
        input logic [core_pkg::REG_AW-1:0] ex_rd,
        input logic [core_pkg::XLEN-1:0]   ex_data,
        input logic                        wb_valid,
        input logic [core_pkg::REG_AW-1:0] wb_rd,
        input logic [core_pkg::XLEN-1:0]   wb_data
    );
        if (ex_valid && ex_rd == addr) begin
            return ex_data;
        end else if (wb_valid && wb_rd == addr) begin
            return wb_data;
        end
        return rf_data;
    endfunction

    assign rs1_addr_o = issue_op_i.rs1;
    assign rs2_addr_o = issue_op_i.rs2;

    always_comb begin
        ex_next.pc      = issue_op_i.pc;
        ex_next.opcode  = issue_op_i.opcode;
        ex_next.rd      = issue_op_i.rd;
        ex_next.imm     = issue_op_i.imm;
        ex_next.rs1_val = bypass(issue_op_i.rs1, rs1_data_i,
                                 ex_fwd_valid_i, ex_fwd_rd_i, ex_fwd_data_i,
                                 wb_fwd_valid_i, wb_fwd_rd_i, wb_fwd_data_i);
        ex_next.rs2_val = bypass(issue_op_i.rs2, rs2_data_i,
                                 ex_fwd_valid_i, ex_fwd_rd_i, ex_fwd_data_i,
                                 wb_fwd_valid_i, wb_fwd_rd_i, wb_fwd_data_i);
    end

    // ========================================
    // Execute pipeline register
    // ========================================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_op_o <= ex_next;
    end

endmodule

`default_nettype wire

// File: source/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  logic                          clk,
    input  logic                          we_i,
    input  logic [core_pkg::DMEM_AW-1:0]  addr_i,
    input  logic [core_pkg::XLEN-1:0]     wdata_i,
    output logic [core_pkg::XLEN-1:0]     rdata_o
);

    logic [core_pkg::XLEN-1:0] mem [core_pkg::DMEM_WORDS];

    // Write lands at the edge, read is visible in the same cycle
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    assign rdata_o = mem[addr_i];

endmodule

`default_nettype wire

// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

    // ========================================
    // Widths and sizes
    // ========================================
    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = 6;

    // ========================================
    // Encodings
    // ========================================
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_SRL,
        OP_ADDI,
        OP_LUI,
        OP_LOAD,
        OP_STORE,
        OP_LINK,
        OP_CSR
    } opcode_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC,
        WB_CSR
    } wb_sel_e;

    // ========================================
    // Stage payloads
    // ========================================
    typedef struct packed {
        logic [XLEN-1:0]   pc;
        opcode_e           opcode;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   imm;
    } issue_op_t;

    // Operands are already resolved once an op reaches execute
    typedef struct packed {
        logic [XLEN-1:0]   pc;
        opcode_e           opcode;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   rs1_val;
        logic [XLEN-1:0]   rs2_val;
    } ex_op_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        opcode_e           opcode;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   alu_out;
        logic [XLEN-1:0]   mem_rdata;
    } wb_op_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic              we;
        logic [XLEN-1:0]   wdata;
    } retire_t;

endpackage

`default_nettype wire
